//--- Makefile
# Verilator build of the cartridge mapper testbench

VERILATOR ?= verilator
TOP       ?= tb_gb_cart_mapper
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= TESTBENCH PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- build.f
hw/cart_types_pkg.sv
hw/cart_bus_pkg.sv
hw/cart_header_decode.sv
hw/mbc_bank_regs.sv
hw/cart_addr_map.sv
hw/cart_bus_result.sv
hw/gb_cart_mapper.sv
verification/tb_gb_cart_mapper.sv

//--- hw/cart_addr_map.sv
/*
 * cartridge address map
 * turns the cpu address and the bank state into a rom byte address
 * and a cartridge ram address, purely combinational
 */
module cart_addr_map
	import cart_types_pkg::*;
	import cart_bus_pkg::*;
(
	input  cart_wb_req_t           cpu_req,
	input  cart_header_t           header,
	input  mbc_bank_state_t        bank,
	output logic [rom_addr_w-1:0]  rom_addr,
	output logic [cram_addr_w-1:0] cram_addr,
	output logic                   in_ram_window
);

	logic                  mbc1_mode0;
	logic [rom_bank_w-1:0] rom_bank_sel;  // bank register before masking
	logic [rom_bank_w-1:0] rom_bank_eff;
	logic [ram_bank_w-1:0] ram_bank_eff;

	assign mbc1_mode0 = (header.kind == MBC_1) && !bank.mbc1_mode;

	// ------------------------------
	// rom side
	always_comb begin
		rom_bank_sel = bank.rom_bank;
		if (header.kind != MBC_5) rom_bank_sel[8:7] = 2'b00;  // 7 bit controllers
		if (header.kind == MBC_1) begin
			// upper two bank lines come from the ram bank reg in mode 0
			rom_bank_sel[6:5] = mbc1_mode0 ? bank.ram_bank[1:0] : 2'b00;
		end

		if (header.kind == MBC_NONE)
			rom_bank_eff = {8'd0, cpu_req.adr[14]};       // plain 32k rom
		else if (cpu_req.adr[14])
			rom_bank_eff = rom_bank_sel & header.rom_mask;  // switchable window
		else
			rom_bank_eff = '0;                              // fixed bank 0
	end

	assign rom_addr = {rom_bank_eff, cpu_req.adr[13:0]};

	// ------------------------------
	// ram side, 8k windows
	always_comb begin
		if (mbc1_mode0 || header.kind == MBC_2 || header.kind == MBC_NONE)
			ram_bank_eff = '0;
		else
			ram_bank_eff = bank.ram_bank & header.ram_mask;
	end

	assign cram_addr     = {ram_bank_eff, cpu_req.adr[12:0]};
	assign in_ram_window = cpu_req.adr[15:13] == region_ram;

endmodule

//--- hw/cart_bus_pkg.sv
/*
 * cartridge bus definitions
 * wishbone classic request / response of the cpu side, the download
 * word from the host and the address map constants of the cartridge
 */
package cart_bus_pkg;

	localparam int rom_addr_w  = 23;  // 8 MiB rom byte address
	localparam int cram_addr_w = 17;  // 128 KiB cartridge ram

	// ------------------------------
	// cpu address map
	localparam logic [2:0] region_ram     = 3'd5;  // adr[15:13], 0xA000-0xBFFF
	localparam logic [3:0] ram_enable_key = 4'hA;  // low nibble that opens the ram

	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [15:0] adr;
		logic [7:0]  dat_w;
	} cart_wb_req_t;

	typedef struct packed {
		logic       ack;
		logic [7:0] dat_r;
	} cart_wb_rsp_t;

	typedef struct packed {
		logic        valid;
		logic [24:0] addr;  // byte address, even for each word
		logic [15:0] data;  // high byte belongs to the odd address
	} cart_dl_t;

endpackage

//--- hw/cart_bus_result.sv
/*
 * cartridge bus result stage
 * holds the 128k cartridge ram, accepts wishbone transfers and
 * returns the registered read byte with a single cycle ack
 */
module cart_bus_result
	import cart_types_pkg::*;
	import cart_bus_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   reset,
	input  cart_wb_req_t           cpu_req,
	input  logic [cram_addr_w-1:0] cram_addr,
	input  logic                   in_ram_window,
	input  logic [7:0]             rom_data,
	input  mbc_bank_state_t        bank,
	input  cart_header_t           header,
	output logic                   accept,
	output cart_wb_rsp_t           cpu_rsp
);

	logic [7:0] cram [0:(1 << cram_addr_w) - 1];
	logic [7:0] cram_q;
	logic [7:0] rd_byte;
	logic       ack_q;
	logic [7:0] dat_r_q;

	// new request only while no ack is out, so two cycles per transfer
	assign accept = cpu_req.cyc && cpu_req.stb && !ack_q;

	// ------------------------------
	always_ff @(posedge clk_sys) begin
		if (accept && cpu_req.we && in_ram_window && bank.ram_enable)
			cram[cram_addr] <= cpu_req.dat_w;
	end

	assign cram_q = cram[cram_addr];

	always_comb begin
		if (!in_ram_window)
			rd_byte = rom_data;                  // rom port, already mapped
		else if (!bank.ram_enable)
			rd_byte = 8'hFF;                     // closed ram reads high
		else if (bank.rtc_select)
			rd_byte = 8'h00;                     // no clock behind the rtc regs
		else if (header.kind == MBC_2 && cpu_req.adr[12:9] == 4'd0)
			rd_byte = {4'hF, cram_q[3:0]};       // 512 x 4 bit internal ram
		else
			rd_byte = cram_q;
	end

	// ------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) ack_q <= 1'b0;
		else       ack_q <= accept;
	end

	always_ff @(posedge clk_sys) begin
		if (accept) dat_r_q <= rd_byte;  // valid together with ack
	end

	assign cpu_rsp = '{ack: ack_q, dat_r: dat_r_q};

	a_ack_single: assert property (@(posedge clk_sys) disable iff (reset)
		cpu_rsp.ack |=> !cpu_rsp.ack);

endmodule

//--- hw/cart_header_decode.sv
/*
 * cartridge header decode
 * picks the cgb flag, type and size bytes out of the rom download and
 * turns them into the controller kind and the rom / ram bank masks
 */
module cart_header_decode
	import cart_types_pkg::*;
	import cart_bus_pkg::*;
(
	input  logic         clk_sys,
	input  logic         reset,
	input  cart_dl_t     dl,
	output cart_header_t header
);

	logic [7:0] cart_type;
	logic [7:0] rom_code;
	logic [7:0] ram_code;
	logic [7:0] cgb_flag;

	// raw header bytes, taken as the words stream past
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_type <= 8'h00;
			rom_code  <= 8'h00;
			ram_code  <= 8'h00;
			cgb_flag  <= 8'h00;
		end else if (dl.valid) begin
			if (dl.addr == hdr_addr_cgb)  cgb_flag  <= dl.data[15:8];  // byte 0x143
			if (dl.addr == hdr_addr_type) cart_type <= dl.data[15:8];  // byte 0x147
			if (dl.addr == hdr_addr_size) begin
				rom_code <= dl.data[7:0];   // byte 0x148
				ram_code <= dl.data[15:8];  // byte 0x149
			end
		end
	end

	// ------------------------------
	always_comb begin
		case (cart_type)
			8'd1, 8'd2, 8'd3:                        header.kind = MBC_1;
			8'd5, 8'd6:                              header.kind = MBC_2;
			8'd15, 8'd16, 8'd17, 8'd18, 8'd19:       header.kind = MBC_3;
			8'd25, 8'd26, 8'd27, 8'd28, 8'd29, 8'd30: header.kind = MBC_5;
			default:                                 header.kind = MBC_NONE;
		endcase

		// code n means 2^(n+1) banks, odd sized carts fall back to 128
		if (rom_code > 8'd8) header.rom_mask = 9'h07F;
		else                 header.rom_mask = 9'h1FF >> (4'd8 - rom_code[3:0]);

		if (ram_code >= 8'd4)      header.ram_mask = 4'b1111;  // 128k, 16 banks
		else if (ram_code == 8'd3) header.ram_mask = 4'b0011;  // 32k, 4 banks
		else                       header.ram_mask = 4'b0000;  // single bank or none

		header.is_cgb_game = (cgb_flag == cgb_flag_compat) || (cgb_flag == cgb_flag_only);
	end

	// kind only moves on the edge after a type word
	a_kind_from_type: assert property (@(posedge clk_sys) disable iff (reset)
		$changed(header.kind) |-> $past(dl.valid && dl.addr == hdr_addr_type));

endmodule

//--- hw/cart_types_pkg.sv
/*
 * cartridge type definitions
 * header field locations in the download stream, controller kinds,
 * bank widths and the decoded header / bank state records shared by
 * the mapper stages
 */
package cart_types_pkg;

	// ------------------------------
	// header locations, word addresses of the download stream
	localparam logic [24:0] hdr_addr_cgb  = 25'h142;  // cgb flag in high byte
	localparam logic [24:0] hdr_addr_type = 25'h146;  // cartridge type in high byte
	localparam logic [24:0] hdr_addr_size = 25'h148;  // rom size low, ram size high

	localparam logic [7:0] cgb_flag_compat = 8'h80;  // runs on both models
	localparam logic [7:0] cgb_flag_only   = 8'hC0;  // color only

	localparam int rom_bank_w = 9;  // up to 512 banks of 16k
	localparam int ram_bank_w = 4;  // up to 16 banks of 8k

	// ------------------------------
	typedef enum logic [2:0] {
		MBC_NONE,
		MBC_1,
		MBC_2,
		MBC_3,
		MBC_5
	} mbc_kind_e;

	typedef struct packed {
		mbc_kind_e             kind;
		logic [rom_bank_w-1:0] rom_mask;     // mirrors rom banks past the end
		logic [ram_bank_w-1:0] ram_mask;
		logic                  is_cgb_game;
	} cart_header_t;

	typedef struct packed {
		logic [rom_bank_w-1:0] rom_bank;
		logic [ram_bank_w-1:0] ram_bank;
		logic                  ram_enable;
		logic                  mbc1_mode;    // 0: rom banking, 1: ram banking
		logic                  rtc_select;   // mbc3 clock register in the ram window
	} mbc_bank_state_t;

endpackage

//--- hw/gb_cart_mapper.sv
/*
 * handheld cartridge mapper
 * header decode, bank register writes, address mapping and the
 * wishbone result stage behind one cpu slave port
 */
module gb_cart_mapper
	import cart_types_pkg::*;
	import cart_bus_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,
	input  cart_dl_t              dl,        // rom download from the host
	input  cart_wb_req_t          cpu_req,
	output cart_wb_rsp_t          cpu_rsp,
	output logic [rom_addr_w-1:0] rom_addr,
	input  logic [7:0]            rom_data,  // combinational from rom_addr
	output cart_header_t          header
);

	mbc_bank_state_t        bank;
	logic [cram_addr_w-1:0] cram_addr;
	logic                   in_ram_window;
	logic                   accept;

	// decode
	cart_header_decode i_header_decode (
		.clk_sys (clk_sys),
		.reset   (reset),
		.dl      (dl),
		.header  (header)
	);

	// execute
	mbc_bank_regs i_bank_regs (
		.clk_sys (clk_sys),
		.reset   (reset),
		.accept  (accept),
		.cpu_req (cpu_req),
		.header  (header),
		.bank    (bank)
	);

	cart_addr_map i_addr_map (
		.cpu_req       (cpu_req),
		.header        (header),
		.bank          (bank),
		.rom_addr      (rom_addr),
		.cram_addr     (cram_addr),
		.in_ram_window (in_ram_window)
	);

	// result
	cart_bus_result i_bus_result (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cpu_req       (cpu_req),
		.cram_addr     (cram_addr),
		.in_ram_window (in_ram_window),
		.rom_data      (rom_data),
		.bank          (bank),
		.header        (header),
		.accept        (accept),
		.cpu_rsp       (cpu_rsp)
	);

endmodule

//--- hw/mbc_bank_regs.sv
/*
 * mbc bank registers
 * cpu writes into the rom space land here: ram enable, rom bank,
 * ram bank / rtc select and the mbc1 banking mode
 */
module mbc_bank_regs
	import cart_types_pkg::*;
	import cart_bus_pkg::*;
(
	input  logic            clk_sys,
	input  logic            reset,
	input  logic            accept,    // transfer taken this cycle
	input  cart_wb_req_t    cpu_req,
	input  cart_header_t    header,
	output mbc_bank_state_t bank
);

	logic reg_wr;
	logic is_mbc5;

	assign reg_wr  = accept && cpu_req.we && !cpu_req.adr[15];  // 0x0000-0x7FFF
	assign is_mbc5 = header.kind == MBC_5;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bank.rom_bank   <= 9'd1;
			bank.ram_bank   <= 4'd0;
			bank.ram_enable <= 1'b0;
			bank.mbc1_mode  <= 1'b0;
			bank.rtc_select <= 1'b0;
		end else if (reg_wr) begin
			case (cpu_req.adr[14:13])
				// ------------------------------
				2'b00: begin  // ram enable
					bank.ram_enable <= cpu_req.dat_w[3:0] == ram_enable_key;
				end
				// ------------------------------
				2'b01: begin  // rom bank
					if (is_mbc5) begin
						if (cpu_req.adr[12])
							bank.rom_bank[8] <= cpu_req.dat_w[0];  // 0x3000-0x3FFF
						else
							bank.rom_bank[7:0] <= cpu_req.dat_w;   // 0x2000-0x2FFF
					end else if (cpu_req.dat_w[6:0] == 7'd0) begin
						bank.rom_bank <= 9'd1;  // bank 0 can't sit in the upper window
					end else begin
						bank.rom_bank <= {2'b00, cpu_req.dat_w[6:0]};
					end
				end
				// ------------------------------
				2'b10: begin  // ram bank or rtc register
					if (header.kind == MBC_3 && cpu_req.dat_w[3]) begin
						bank.rtc_select <= 1'b1;
					end else begin
						bank.rtc_select <= 1'b0;
						if (is_mbc5)
							bank.ram_bank <= cpu_req.dat_w[3:0];
						else
							bank.ram_bank <= {2'b00, cpu_req.dat_w[1:0]};
					end
				end
				// ------------------------------
				default: begin  // banking mode, mbc1 only
					if (header.kind == MBC_1) bank.mbc1_mode <= cpu_req.dat_w[0];
				end
			endcase
		end
	end

	// accept comes from the result stage, must track the live request
	a_accept_needs_req: assert property (@(posedge clk_sys) disable iff (reset)
		accept |-> (cpu_req.cyc && cpu_req.stb));

endmodule

//--- verification/tb_gb_cart_mapper.sv
/*
 * testbench for the cartridge mapper
 * directed tests over linear rom, mbc1 / mbc5 rom banking, banked
 * cartridge ram, mbc2 nibble reads and the mbc3 rtc select
 */
module tb_gb_cart_mapper
	import cart_types_pkg::*;
	import cart_bus_pkg::*;
();

	localparam int reset_cycles = 16;
	localparam int n_xfers      = 31;  // bus transfers over all tests
	localparam int n_loads      = 5;   // header downloads
	// 3 cycles per transfer, 5 per header load, doubled for slack
	localparam int max_cycles = 2 * (reset_cycles + 3 * n_xfers + 5 * n_loads);

	logic                  clk_sys = 1'b0;
	logic                  reset;
	cart_dl_t              dl;
	cart_wb_req_t          cpu_req;
	cart_wb_rsp_t          cpu_rsp;
	logic [rom_addr_w-1:0] rom_addr;
	logic [7:0]            rom_data;
	cart_header_t          header;
	logic [rom_addr_w-1:0] seen_rom_addr;  // rom address during the last transfer
	int                    cycle_cnt = 0;
	integer                seed = 32'hfe2b;

	always #5 clk_sys = ~clk_sys;

	// rom model, byte from low and high address bits
	function automatic logic [7:0] rom_model(input logic [rom_addr_w-1:0] a);
		return a[7:0] ^ a[22:15];
	endfunction

	assign rom_data = rom_model(rom_addr);

	gb_cart_mapper i_dut (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.dl       (dl),
		.cpu_req  (cpu_req),
		.cpu_rsp  (cpu_rsp),
		.rom_addr (rom_addr),
		.rom_data (rom_data),
		.header   (header)
	);

	// ------------------------------
	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= max_cycles) begin
			$display("timeout: the tests did not finish within %0d cycles", max_cycles);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	end

	// ------------------------------
	// one wishbone classic transfer, held until ack
	task automatic bus_xfer(input logic wr, input logic [15:0] adr, input logic [7:0] wdata,
			output logic [7:0] rdata);
		@(posedge clk_sys);
		cpu_req.cyc   <= 1'b1;
		cpu_req.stb   <= 1'b1;
		cpu_req.we    <= wr;
		cpu_req.adr   <= adr;
		cpu_req.dat_w <= wdata;
		do begin
			@(negedge clk_sys);  // mid cycle, outputs settled
		end while (!cpu_rsp.ack);
		rdata         = cpu_rsp.dat_r;
		seen_rom_addr = rom_addr;  // request still held here
		@(posedge clk_sys);
		cpu_req.cyc <= 1'b0;
		cpu_req.stb <= 1'b0;
		cpu_req.we  <= 1'b0;
	endtask

	task automatic write_reg(input logic [15:0] adr, input logic [7:0] wdata);
		logic [7:0] unused;
		bus_xfer(1'b1, adr, wdata, unused);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got == exp)
		else begin
			$display("error: %s is 0x%h, expected 0x%h", name, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_read(input logic [15:0] adr, input logic [7:0] exp);
		logic [7:0] got;
		bus_xfer(1'b0, adr, 8'h00, got);
		assert (got == exp)
		else begin
			$display("error: cpu_rsp.dat_r at adr 0x%h is 0x%h, expected 0x%h", adr, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	endtask

	// rom read, checks the mapped address and the byte behind it
	task automatic check_rom(input logic [15:0] adr, input logic [rom_addr_w-1:0] exp_addr);
		check_read(adr, rom_model(exp_addr));
		check_value("rom_addr", 32'(seen_rom_addr), 32'(exp_addr));
	endtask

	// header words as the host download sends them
	task automatic load_header(input logic [7:0] type_code, input logic [7:0] rom_code,
			input logic [7:0] ram_code, input logic [7:0] cgb);
		@(posedge clk_sys);
		dl.valid <= 1'b1;
		dl.addr  <= hdr_addr_cgb;
		dl.data  <= {cgb, 8'h00};
		@(posedge clk_sys);
		dl.addr  <= hdr_addr_type;
		dl.data  <= {type_code, 8'h00};
		@(posedge clk_sys);
		dl.addr  <= hdr_addr_size;
		dl.data  <= {ram_code, rom_code};  // rom size at the even byte
		@(posedge clk_sys);
		dl.valid <= 1'b0;
		@(posedge clk_sys);                // header fields settled
	endtask

	// ------------------------------
	task automatic test_linear_rom();
		check_rom(16'h0123, 23'h000123);
		check_rom(16'h7FFF, 23'h007FFF);  // no mbc, upper half is plain rom
	endtask

	task automatic test_mbc1_rom();
		load_header(8'h01, 8'h02, 8'h00, 8'h00);
		check_value("header.kind", 32'(header.kind), 32'(MBC_1));
		check_value("header.rom_mask", 32'(header.rom_mask), 32'h007);
		write_reg(16'h2000, 8'h00);               // zero turns into bank 1
		check_rom(16'h4000, {9'd1, 14'h0000});
		write_reg(16'h2000, 8'h1D);               // 29 masked to 8 banks
		check_rom(16'h4000, {9'd5, 14'h0000});
	endtask

	task automatic test_mbc5_rom();
		load_header(8'h19, 8'h08, 8'h00, 8'h00);
		write_reg(16'h2000, 8'h34);               // low byte
		write_reg(16'h3000, 8'h01);               // bank bit 8
		check_rom(16'h4000, {9'h134, 14'h0000});
	endtask

	task automatic test_mbc1_ram();
		logic [31:0] rnd;
		logic [7:0]  d0;
		load_header(8'h03, 8'h02, 8'h03, 8'h00);
		check_value("header.ram_mask", 32'(header.ram_mask), 32'h3);  // 4 banks of 8k
		write_reg(16'h0000, 8'h00);
		check_read(16'hA010, 8'hFF);              // closed ram
		write_reg(16'h0000, 8'h0A);
		rnd = $random(seed);
		d0  = rnd[7:0];
		write_reg(16'hA010, d0);
		check_read(16'hA010, d0);
		write_reg(16'h6000, 8'h01);               // ram banking mode
		write_reg(16'h4000, 8'h02);
		write_reg(16'hA010, ~d0);
		check_read(16'hA010, ~d0);
		write_reg(16'h4000, 8'h00);
		check_read(16'hA010, d0);                 // bank 0 kept its byte
	endtask

	task automatic test_mbc2_nibble();
		load_header(8'h05, 8'h02, 8'h00, 8'h00);
		write_reg(16'h0000, 8'h0A);
		write_reg(16'hA004, 8'h5C);
		check_read(16'hA004, 8'hFC);              // upper nibble reads as ones
	endtask

	task automatic test_mbc3_rtc();
		load_header(8'h13, 8'h02, 8'h03, 8'hC0);
		check_value("header.kind", 32'(header.kind), 32'(MBC_3));
		check_value("header.is_cgb_game", 32'(header.is_cgb_game), 32'h1);
		write_reg(16'h0000, 8'h0A);
		write_reg(16'h4000, 8'h00);
		write_reg(16'hA020, 8'hB7);
		check_read(16'hA020, 8'hB7);
		write_reg(16'h4000, 8'h08);               // rtc register in the window
		check_read(16'hA020, 8'h00);
		write_reg(16'h4000, 8'h00);
		check_read(16'hA020, 8'hB7);
	endtask

	// ------------------------------
	initial begin
		reset   = 1'b1;
		dl      = '0;
		cpu_req = '0;
		repeat (reset_cycles) @(posedge clk_sys);
		reset <= 1'b0;
		test_linear_rom();
		test_mbc1_rom();
		test_mbc5_rom();
		test_mbc1_ram();
		test_mbc2_nibble();
		test_mbc3_rtc();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule
